/* flist.f */
hdl/dm_pkg.sv
hdl/dm_ifs.sv
hdl/dm_array.sv
hdl/dm_clear_seq.sv
hdl/dm_regs.sv
hdl/dm_wb_slave.sv
hdl/dm_subsys.sv
verification/dm_subsys_props.sv
verification/dm_subsys_tb.sv

/* verification/dm_subsys_tb.sv */
`default_nettype none

module dm_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  // twice the cycles of two full sweeps plus bus traffic
  localparam int WATCHDOG_NS = (2 * dm_pkg::MEM_WORDS + 1500) * CLK_PERIOD * 2;
  localparam int WR_OK = 6;
  localparam int WR_REFUSED = 3;

  logic                      clk;
  logic                      rst;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [dm_pkg::WB_AW-1:0]  wb_adr;
  logic [dm_pkg::DATA_W-1:0] wb_dat_w;
  logic [dm_pkg::DATA_W-1:0] wb_dat_r;
  logic                      wb_ack;
  logic                      wb_err;

  // expected memory contents
  logic [dm_pkg::DATA_W-1:0] model [dm_pkg::MEM_WORDS] = '{default: '0};
  // every address touched so far
  logic [dm_pkg::MEM_AW-1:0] written [$];
  logic [31:0]               rng;
  int                        errors;
  int                        tests;

  dm_subsys dm_subsys_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // region bit set and offset in the low bits
  function automatic logic [dm_pkg::WB_AW-1:0] reg_adr(input logic [dm_pkg::REG_AW-1:0] off);
    logic [dm_pkg::WB_AW-1:0] a;
    a = '0;
    a[dm_pkg::REG_SEL_BIT] = 1'b1;
    a[dm_pkg::REG_AW-1:0] = off;
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %s finished, %0d errors so far", name, errors);
  endtask

  // one classic write held until ack or err
  task automatic wb_write(input logic [dm_pkg::WB_AW-1:0] adr, input logic [31:0] dat,
                          output logic err);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      @(negedge clk);
    end while (!wb_ack && !wb_err);
    err    = wb_err;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // one classic read
  // lat counts cycles until the answer
  task automatic wb_read(input logic [dm_pkg::WB_AW-1:0] adr, output logic [31:0] dat,
                         output logic err, output int lat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    lat    = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!wb_ack && !wb_err);
    dat    = wb_dat_r;
    err    = wb_err;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // model follows only writes that are taken
  task automatic mem_write(input logic [dm_pkg::MEM_AW-1:0] addr, input logic [31:0] dat,
                           input logic exp_err);
    logic err;
    wb_write(dm_pkg::WB_AW'(addr), dat, err);
    check_value("wb_err", err, exp_err);
    if (!exp_err) begin
      model[addr] = dat;
    end
  endtask

  task automatic mem_read_check(input logic [dm_pkg::MEM_AW-1:0] addr);
    logic [31:0] dat;
    logic        err;
    int          lat;
    wb_read(dm_pkg::WB_AW'(addr), dat, err, lat);
    check_value("wb_err", err, 0);
    check_value("wb_dat_r", dat, model[addr]);
    // fetch cycle plus data cycle with no sweep running
    check_value("memory read latency", lat, 2);
  endtask

  task automatic reg_write(input logic [dm_pkg::REG_AW-1:0] off, input logic [31:0] dat);
    logic err;
    wb_write(reg_adr(off), dat, err);
    check_value("wb_err", err, 0);
  endtask

  task automatic reg_read(input logic [dm_pkg::REG_AW-1:0] off, output logic [31:0] dat);
    logic err;
    int   lat;
    wb_read(reg_adr(off), dat, err, lat);
    check_value("wb_err", err, 0);
    // registers answer in one cycle even mid sweep
    check_value("register read latency", lat, 1);
  endtask

  task automatic test_reset_clear();
    logic [31:0] status;
    // sweep started at reset release
    do begin
      reg_read(dm_pkg::REG_STATUS, status);
    end while (status[0]);
    mem_read_check('0);
    mem_read_check(dm_pkg::MEM_AW'(dm_pkg::MEM_WORDS - 1));
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      mem_read_check(rng[dm_pkg::MEM_AW-1:0]);
    end
    report_test("reset clear");
  endtask

  task automatic test_read_back();
    logic [dm_pkg::MEM_AW-1:0] addrs [20];
    for (int i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      addrs[i] = rng[dm_pkg::MEM_AW-1:0];
      rng = xorshift32(rng);
      mem_write(addrs[i], rng, 1'b0);
      written.push_back(addrs[i]);
    end
    // repeated addresses resolve through the model
    foreach (addrs[i]) begin
      mem_read_check(addrs[i]);
    end
    report_test("read back");
  endtask

  task automatic test_write_protect();
    logic [31:0] limit;
    mem_write(12'd5, 32'h5a5a_0005, 1'b0);
    reg_write(dm_pkg::REG_PROT_LIMIT, 32'd16);
    // refused write leaves the old word
    mem_write(12'd5, 32'hdead_beef, 1'b1);
    mem_read_check(12'd5);
    // first word above the limit
    mem_write(12'd16, 32'h1234_0016, 1'b0);
    mem_read_check(12'd16);
    reg_read(dm_pkg::REG_PROT_LIMIT, limit);
    check_value("prot_limit", limit, 32'd16);
    written.push_back(12'd5);
    written.push_back(12'd16);
    report_test("write protection");
  endtask

  task automatic test_wr_count();
    logic [31:0]               count;
    logic [dm_pkg::MEM_AW-1:0] addr;
    reg_write(dm_pkg::REG_WR_COUNT, 32'hffff_ffff);
    for (int i = 0; i < WR_OK; i++) begin
      rng = xorshift32(rng);
      // limit is still 16
      addr = dm_pkg::MEM_AW'(16 + rng % (dm_pkg::MEM_WORDS - 16));
      rng = xorshift32(rng);
      mem_write(addr, rng, 1'b0);
      written.push_back(addr);
    end
    for (int i = 0; i < WR_REFUSED; i++) begin
      rng = xorshift32(rng);
      mem_write(dm_pkg::MEM_AW'(rng % 16), rng, 1'b1);
    end
    reg_read(dm_pkg::REG_WR_COUNT, count);
    check_value("wr_count", count, WR_OK);
    report_test("write counter");
  endtask

  task automatic test_soft_clear();
    logic [31:0] status;
    logic [31:0] dat;
    logic        err;
    int          lat;
    reg_write(dm_pkg::REG_CTRL, 32'd1);
    reg_read(dm_pkg::REG_STATUS, status);
    check_value("clear_busy", status, 32'd1);
    // register side keeps answering mid sweep
    reg_read(dm_pkg::REG_PROT_LIMIT, dat);
    check_value("prot_limit", dat, 32'd16);
    // memory read parks until the sweep is over
    wb_read(dm_pkg::WB_AW'(written[0]), dat, err, lat);
    check_value("wb_err", err, 0);
    check_value("wb_dat_r", dat, 0);
    if (lat < dm_pkg::MEM_WORDS - 64) begin
      $display("memory read answered after %0d cycles, before the clear could end", lat);
      errors++;
    end
    reg_read(dm_pkg::REG_STATUS, status);
    check_value("clear_busy", status, 0);
    foreach (model[i]) begin
      model[i] = '0;
    end
    foreach (written[i]) begin
      mem_read_check(written[i]);
    end
    report_test("software clear");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    errors   = 0;
    tests    = 0;
    rng      = 32'hb250;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_clear();
    test_read_back();
    test_write_protect();
    test_wr_count();
    test_soft_clear();
    errors += dm_subsys_i.dm_wb_slave_i.dm_subsys_props_i.failures;
    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/dm_subsys_props.sv */
`default_nettype none

// wishbone classic handshake rules at the slave
module dm_subsys_props (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic wb_err
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far
  int failures = 0;

  // never both answers at once
  ack_err_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(wb_ack && wb_err))
    else begin
      $error("wb_ack and wb_err high in the same cycle");
      failures++;
    end

  // an answer lasts one cycle only
  answer_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (wb_ack || wb_err) |=> !(wb_ack || wb_err))
    else begin
      $error("wb_ack or wb_err held longer than one cycle");
      failures++;
    end

  // registered answer needs the request at the previous edge
  answer_needs_request: assert property (@(posedge clk) disable iff (rst)
    (wb_ack || wb_err) |-> $past(wb_cyc && wb_stb))
    else begin
      $error("answer without cyc and stb");
      failures++;
    end

  // quiet bus right after reset
  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!wb_ack && !wb_err))
    else begin
      $error("wb_ack or wb_err high after reset");
      failures++;
    end

endmodule

bind dm_wb_slave dm_subsys_props dm_subsys_props_i (
  .clk    (clk),
  .rst    (rst),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .wb_err (wb_err)
);

`default_nettype wire

/* hdl/dm_subsys.sv */
`default_nettype none

module dm_subsys (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [dm_pkg::WB_AW-1:0]  wb_adr,
  input  logic [dm_pkg::DATA_W-1:0] wb_dat_w,
  output logic [dm_pkg::DATA_W-1:0] wb_dat_r,
  output logic                      wb_ack,
  output logic                      wb_err
);

  logic                      clear_start;
  logic                      clear_busy;
  logic                      wr_done;
  logic [dm_pkg::MEM_AW-1:0] prot_limit;

  // slave to sequencer
  dm_mem_if bus_mem ();
  // sequencer to array
  dm_mem_if arr_mem ();
  dm_reg_if reg_bus ();

  dm_wb_slave dm_wb_slave_i (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .mem        (bus_mem.requester),
    .regs       (reg_bus.master),
    .prot_limit (prot_limit),
    .wr_done    (wr_done)
  );

  dm_regs dm_regs_i (
    .clk         (clk),
    .rst         (rst),
    .regs        (reg_bus.bank),
    .clear_busy  (clear_busy),
    .wr_done     (wr_done),
    .clear_start (clear_start),
    .prot_limit  (prot_limit)
  );

  dm_clear_seq dm_clear_seq_i (
    .clk         (clk),
    .rst         (rst),
    .clear_start (clear_start),
    .clear_busy  (clear_busy),
    .bus         (bus_mem.arbiter),
    .mem         (arr_mem.requester)
  );

  dm_array dm_array_i (
    .clk (clk),
    .rst (rst),
    .mem (arr_mem.memory)
  );

endmodule

`default_nettype wire

/* hdl/dm_wb_slave.sv */
`default_nettype none

module dm_wb_slave (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [dm_pkg::WB_AW-1:0]  wb_adr,
  input  logic [dm_pkg::DATA_W-1:0] wb_dat_w,
  output logic [dm_pkg::DATA_W-1:0] wb_dat_r,
  output logic                      wb_ack,
  output logic                      wb_err,
  dm_mem_if.requester               mem,
  dm_reg_if.master                  regs,
  input  logic [dm_pkg::MEM_AW-1:0] prot_limit,
  output logic                      wr_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_RDY,
    ST_FETCH,
    ST_RESP
  } state_t;

  state_t state;
  logic   req;
  logic   reg_hit;
  logic   prot_hit;
  logic   mem_phase;

  assign req      = wb_cyc && wb_stb;
  assign reg_hit  = wb_adr[dm_pkg::REG_SEL_BIT];
  // memory write below the limit is refused
  assign prot_hit = wb_we && !reg_hit && (wb_adr[dm_pkg::MEM_AW-1:0] < prot_limit);
  // states where a memory request may be on the port
  assign mem_phase = (state == ST_IDLE) || (state == ST_WAIT_RDY);

  // register access, one cycle, only decoded from idle
  assign regs.sel    = (state == ST_IDLE) && req && reg_hit;
  assign regs.we     = wb_we;
  assign regs.offset = wb_adr[dm_pkg::REG_AW-1:0];
  assign regs.wdata  = wb_dat_w;

  // memory request held straight from the bus until ready
  assign mem.en    = mem_phase && req && !reg_hit && !prot_hit;
  assign mem.fetch = !wb_we;
  assign mem.write = wb_we;
  assign mem.addr  = wb_adr[dm_pkg::MEM_AW-1:0];
  assign mem.wdata = wb_dat_w;

  // one pulse per accepted write
  assign wr_done = mem.en && mem.ready && wb_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      // responses last a single cycle
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      case (state)
        ST_IDLE, ST_WAIT_RDY: begin
          if (regs.sel) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= regs.rdata;
            state    <= ST_RESP;
          end else if ((state == ST_IDLE) && req && prot_hit) begin
            wb_err <= 1'b1;
            state  <= ST_RESP;
          end else if (mem.en) begin
            if (!mem.ready) begin
              // clear running, keep the request up
              state <= ST_WAIT_RDY;
            end else if (wb_we) begin
              wb_ack <= 1'b1;
              state  <= ST_RESP;
            end else begin
              state <= ST_FETCH;
            end
          end else if (!req) begin
            // master gave up while waiting
            state <= ST_IDLE;
          end
        end
        ST_FETCH: begin
          // array data valid now
          wb_ack   <= 1'b1;
          wb_dat_r <= mem.rdata;
          state    <= ST_RESP;
        end
        default: begin
          // master drops stb here, no second answer
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/dm_regs.sv */
`default_nettype none

module dm_regs (
  input  logic                      clk,
  input  logic                      rst,
  dm_reg_if.bank                    regs,
  input  logic                      clear_busy,
  input  logic                      wr_done,
  output logic                      clear_start,
  output logic [dm_pkg::MEM_AW-1:0] prot_limit
);

  logic [dm_pkg::DATA_W-1:0] wr_count;
  logic                      reg_wr;

  assign reg_wr = regs.sel && regs.we;

  // start pulse, dropped while a sweep is already running
  always_ff @(posedge clk) begin
    if (rst) begin
      clear_start <= 1'b0;
    end else begin
      clear_start <= reg_wr && (regs.offset == dm_pkg::REG_CTRL) &&
                     regs.wdata[0] && !clear_busy;
    end
  end

  // protection limit, word granular
  always_ff @(posedge clk) begin
    if (rst) begin
      prot_limit <= '0;
    end else if (reg_wr && (regs.offset == dm_pkg::REG_PROT_LIMIT)) begin
      prot_limit <= regs.wdata[dm_pkg::MEM_AW-1:0];
    end
  end

  // write counter, sticks at all ones
  // software write of any value zeroes it
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_count <= '0;
    end else if (reg_wr && (regs.offset == dm_pkg::REG_WR_COUNT)) begin
      wr_count <= '0;
    end else if (wr_done && (wr_count != '1)) begin
      wr_count <= wr_count + 1'b1;
    end
  end

  // readback mux
  always_comb begin
    case (regs.offset)
      dm_pkg::REG_CTRL:       regs.rdata = '0;
      dm_pkg::REG_STATUS:     regs.rdata = dm_pkg::DATA_W'(clear_busy);
      dm_pkg::REG_PROT_LIMIT: regs.rdata = dm_pkg::DATA_W'(prot_limit);
      default:                regs.rdata = wr_count;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/dm_clear_seq.sv */
`default_nettype none

module dm_clear_seq (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_start,
  output logic        clear_busy,
  dm_mem_if.arbiter   bus,
  dm_mem_if.requester mem
);

  logic                      busy;
  logic [dm_pkg::MEM_AW-1:0] clr_addr;
  logic                      last_word;

  assign last_word = (clr_addr == dm_pkg::MEM_AW'(dm_pkg::MEM_WORDS - 1));

  // sweep every word once, starting right out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b1;
      clr_addr <= '0;
    end else if (busy) begin
      clr_addr <= clr_addr + 1'b1;
      // counter wraps back to 0 on the last word
      if (last_word) begin
        busy <= 1'b0;
      end
    end else if (clear_start) begin
      busy     <= 1'b1;
      clr_addr <= '0;
    end
  end

  assign clear_busy = busy;

  // sequencer owns the port while busy
  assign mem.en    = busy ? 1'b1 : bus.en;
  assign mem.fetch = busy ? 1'b0 : bus.fetch;
  assign mem.write = busy ? 1'b1 : bus.write;
  assign mem.addr  = busy ? clr_addr : bus.addr;
  assign mem.wdata = busy ? '0 : bus.wdata;

  // bus side waits until the sweep is done
  assign bus.ready = !busy && mem.ready;
  // fetch data is untouched by clear writes
  assign bus.rdata = mem.rdata;

endmodule

`default_nettype wire

/* hdl/dm_array.sv */
`default_nettype none

module dm_array (
  input  logic      clk,
  input  logic      rst,
  dm_mem_if.memory  mem
);

  logic [dm_pkg::DATA_W-1:0] mem_data [dm_pkg::MEM_WORDS];

  // single port, never stalls
  assign mem.ready = 1'b1;

  // registered fetch, data shows up the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      mem.rdata <= '0;
    end else if (mem.en && mem.fetch) begin
      mem.rdata <= mem_data[mem.addr];
    end
  end

  // store only when not fetching
  always_ff @(posedge clk) begin
    if (mem.en && !mem.fetch && mem.write) begin
      mem_data[mem.addr] <= mem.wdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/dm_ifs.sv */
`default_nettype none

// single word memory port
// request taken in any cycle with en and ready both high
interface dm_mem_if;

  logic                      en;
  logic                      fetch;
  logic                      write;
  logic [dm_pkg::MEM_AW-1:0] addr;
  logic [dm_pkg::DATA_W-1:0] wdata;
  logic [dm_pkg::DATA_W-1:0] rdata;
  logic                      ready;

  // side that issues requests
  modport requester (output en, fetch, write, addr, wdata, input rdata, ready);
  // side that accepts and forwards requests
  modport arbiter (input en, fetch, write, addr, wdata, output rdata, ready);
  // the storage itself
  modport memory (input en, fetch, write, addr, wdata, output rdata, ready);

endinterface

// register bank access, one cycle per access
// rdata follows offset combinationally
interface dm_reg_if;

  logic                      sel;
  logic                      we;
  logic [dm_pkg::REG_AW-1:0] offset;
  logic [dm_pkg::DATA_W-1:0] wdata;
  logic [dm_pkg::DATA_W-1:0] rdata;

  modport master (output sel, we, offset, wdata, input rdata);
  modport bank (input sel, we, offset, wdata, output rdata);

endinterface

`default_nettype wire

/* hdl/dm_pkg.sv */
`default_nettype none

package dm_pkg;

  // data path
  localparam int DATA_W = 32;

  // memory geometry, one word per address
  localparam int MEM_AW = 12;
  localparam int MEM_WORDS = 4096;

  // wishbone word address, top bit picks the region
  localparam int WB_AW = 14;
  // set means register bank, clear means memory
  localparam int REG_SEL_BIT = 13;

  // register offsets taken from adr[1:0]
  localparam int REG_AW = 2;
  // bit 0 write starts a clear, reads 0
  localparam logic [REG_AW-1:0] REG_CTRL = 2'd0;
  // bit 0 clear busy, read only
  localparam logic [REG_AW-1:0] REG_STATUS = 2'd1;
  // words below this are write protected
  localparam logic [REG_AW-1:0] REG_PROT_LIMIT = 2'd2;
  // committed memory writes, any write zeroes it
  localparam logic [REG_AW-1:0] REG_WR_COUNT = 2'd3;

endpackage

`default_nettype wire
